/* verif/issue_testdata.txt */
// three words per line: flags, slot 0, slot 1 (flags bit0 hold, bit1 flush, bit2 irq, bit3 end)
// slot word V O RD RJ RK IMMM: V bit3 valid and bits 1:0 exc, O opcode, IMMM sign-extended
0 810100000005 810200000007
0 810301020000 820401020000
0 830503040000 840603050000
0 850704030000 860807000004
0 870908000003 880a0400ffff
0 890b0000abcd 810c0b000001
0 810d0000fff0 810d0c000000
0 810e0d000000 820f0e0d0000
0 861008010000 87110b020000
0 881201020000 88130b010000
// illegal and fetch exceptions, one in slot 1, one marked empty but excepting
0 a00000000000 811405000002
0 b01500000000 811502000009
0 811601000001 a01700000000
0 200000000000 000000000000
// empty slot 0 and interrupt tagging
0 000000000000 811801000003
4 811901000004 811a02000005
4 000000000000 811b01000006
4 b00000000000 811c01000001
0 800000000000 811d01000007
0 810001000001 811e00000002
// hold fills the buffer, flush drops what is still queued
1 811f1e000001 81011f000001
1 810201000010 810302000020
1 810401000030 810502000040
2 810601000050 810702000060
0 810801060001 810907000001
0 000000000000 000000000000
5 810a01000001 810b0a000002
0 830c0b0a0000 890d00001234
0 860e0c000001 870f0e0d0000
8 000000000000 000000000000

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_dual_issue_core -f flist.f -o tb_dual_issue_core

out=$(./obj_dir/tb_dual_issue_core 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

/* flist.f */
design/issue_pkg.sv
design/issue_buffer.sv
design/alu_lane.sv
design/reg_file.sv
design/dual_issue_core.sv
verif/tb_dual_issue_core.sv

/* verif/tb_dual_issue_core.sv */
// self-checking testbench for the dual-issue back end
// replays slot pairs from verif/issue_testdata.txt and checks retires and take against a model

`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;
    import issue_pkg::*;

    localparam int MAX_WORDS = 256;
    localparam int TIMEOUT   = 200;

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic       hold;
    logic       irq;
    slot_t      fetch  [NUM_LANES];
    logic [1:0] take;
    retire_t    retire [NUM_LANES];

    logic [47:0]     tdata [MAX_WORDS];
    logic [31:0]     rng;
    logic [XLEN-1:0] next_pc;
    int              n_retired;

    // model register array, buffered uops and records due next cycle
    logic [XLEN-1:0] mregs [NUM_REGS];
    uop_t            mbuf  [$];
    retire_t         exp_ret [NUM_LANES];
    slot_t           pend    [NUM_LANES];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    dual_issue_core i_dual_issue_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .hold   (hold),
        .irq    (irq),
        .fetch  (fetch),
        .take   (take),
        .retire (retire)
    );

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // data word holds valid and exc, op, rd, rj, rk and a 16-bit imm
    function automatic slot_t unpack_slot(logic [47:0] w, logic [XLEN-1:0] pc);
        slot_t s;
        s.valid   = w[47];
        s.uop.exc = exc_e'(w[45:44]);
        s.uop.op  = opcode_e'(w[43:40]);
        s.uop.rd  = w[36:32];
        s.uop.rj  = w[28:24];
        s.uop.rk  = w[20:16];
        s.uop.imm = {{16{w[15]}}, w[15:0]};
        s.uop.pc  = pc;
        return s;
    endfunction

    function automatic logic is_empty(slot_t s);
        return !s.valid && (s.uop.exc == EXC_NONE);
    endfunction

    function automatic logic pairable(uop_t older, uop_t younger);
        logic reads_older;
        reads_older = (older.rd != '0)
                    && ((older.rd == younger.rj) || (older.rd == younger.rk));
        return (younger.op != OP_NOP) && (younger.exc == EXC_NONE) && !reads_older;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(uop_t u);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = mregs[u.rj];
        b = (u.rk == '0) ? u.imm : mregs[u.rk];
        case (u.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_LUI:  return u.imm << 12;
            default: return '0;
        endcase
    endfunction

    // in-order evaluation so each uop sees all older writes
    task automatic execute_model(uop_t u, output retire_t r);
        r.valid  = 1'b1;
        r.pc     = u.pc;
        r.rd     = u.rd;
        r.exc    = u.exc;
        r.wen    = (u.op != OP_NOP) && (u.rd != '0) && (u.exc == EXC_NONE);
        r.result = (u.exc == EXC_NONE) ? alu_model(u) : '0;
        if (r.wen) begin
            mregs[u.rd] = r.result;
        end
    endtask

    task automatic fail_now(string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_retire(string name, retire_t exp, retire_t act);
        if ((act.valid !== exp.valid) || (exp.valid && (act !== exp))) begin
            fail_now($sformatf("[ERROR] %0t %s expected %h actual %h",
                               $time, name, exp, act));
        end
        if (exp.valid) begin
            n_retired++;
        end
    endtask

    task automatic check_take(logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("[ERROR] %0t take expected %0d actual %0d", $time, exp, act));
        end
    endtask

    // one clock of checking last cycle's retires, driving inputs and stepping the model
    task automatic run_cycle(logic f_hold, logic f_flush, logic f_irq);
        int         acc;
        logic [1:0] exp_take;
        uop_t       u;
        retire_t    nxt [NUM_LANES];
        @(negedge clk);
        check_retire("retire[0]", exp_ret[0], retire[0]);
        check_retire("retire[1]", exp_ret[1], retire[1]);
        rng   = xorshift(rng);
        hold  = f_hold || (rng[2:0] == 3'd0);
        flush = f_flush;
        irq   = f_irq;
        fetch = pend;
        #1;
        nxt[0] = '0;
        nxt[1] = '0;
        if (!flush && !hold && (mbuf.size() > 0)) begin
            u = mbuf.pop_front();
            // a plain NOP drains without a strobe
            if ((u.op != OP_NOP) || (u.exc != EXC_NONE)) begin
                execute_model(u, nxt[0]);
                if ((mbuf.size() > 0) && pairable(u, mbuf[0])) begin
                    execute_model(mbuf.pop_front(), nxt[1]);
                end
            end
        end
        exp_take = flush ? 2'd0 : 2'(2 - mbuf.size());
        check_take(exp_take, take);
        acc = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (!is_empty(pend[k]) && (acc < int'(exp_take))) begin
                u = pend[k].uop;
                if ((acc == 0) && irq && (u.exc == EXC_NONE)) begin
                    u.exc = EXC_INT;
                end
                if (u.exc != EXC_NONE) begin
                    u.op = OP_NOP;
                end
                mbuf.push_back(u);
                pend[k] = '0;
                acc++;
            end
        end
        if (flush) begin
            mbuf.delete();
        end
        exp_ret = nxt;
    endtask

    initial begin
        int          w;
        int          waited;
        logic        done;
        logic [47:0] flags;
        rst_n = 1'b0;
        flush = 1'b0;
        hold  = 1'b0;
        irq   = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            fetch[k]   = '0;
            pend[k]    = '0;
            exp_ret[k] = '0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            mregs[r] = '0;
        end
        rng       = 32'h2bb79eed;
        next_pc   = 32'h0000_1000;
        n_retired = 0;
        $readmemh("verif/issue_testdata.txt", tdata);
        if ($isunknown(tdata[0])) begin
            fail_now("test data file could not be read");
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_take(2'd2, take);

        w    = 0;
        done = 1'b0;
        while (!done && (w + 2 < MAX_WORDS)) begin
            flags = tdata[w];
            if (flags[3] === 1'b1) begin
                done = 1'b1;
            end else begin
                pend[0] = unpack_slot(tdata[w+1], next_pc);
                pend[1] = unpack_slot(tdata[w+2], next_pc + 32'd4);
                next_pc = next_pc + 32'd8;
                // line flags only apply to the first cycle the pair is shown
                run_cycle(flags[0], flags[1], flags[2]);
                waited = 1;
                while (!is_empty(pend[0]) || !is_empty(pend[1])) begin
                    if (waited >= TIMEOUT) begin
                        fail_now("timeout: offered fetch slots were never accepted");
                    end
                    run_cycle(1'b0, 1'b0, 1'b0);
                    waited++;
                end
                w = w + 3;
            end
        end
        if (!done) begin
            fail_now("test data ends without an end marker");
        end

        waited = 0;
        while ((mbuf.size() != 0) || exp_ret[0].valid || exp_ret[1].valid) begin
            if (waited >= TIMEOUT) begin
                fail_now("timeout: buffered instructions never retired");
            end
            run_cycle(1'b0, 1'b0, 1'b0);
            waited++;
        end
        if (n_retired == 0) begin
            fail_now("no instruction retired during the run");
        end else begin
            $display("%0d retire records checked", n_retired);
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* design/dual_issue_core.sv */
// top level of the dual-issue back end
// fetch slots in, take count and per-lane retire records out

`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               hold,
    input  logic               irq,
    input  issue_pkg::slot_t   fetch  [issue_pkg::NUM_LANES],
    output logic [1:0]         take,
    output issue_pkg::retire_t retire [issue_pkg::NUM_LANES]
);
    import issue_pkg::*;

    issue_t                issue   [NUM_LANES];
    logic [REG_ADDR_W-1:0] rd_addr [NUM_RD_PORTS];
    logic [XLEN-1:0]       rd_data [NUM_RD_PORTS];

    issue_buffer i_issue_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .irq   (irq),
        .fetch (fetch),
        .take  (take),
        .issue (issue)
    );

    // ports 2i and 2i+1 serve lane i
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign rd_addr[2*i]   = issue[i].uop.rj;
        assign rd_addr[2*i+1] = issue[i].uop.rk;

        alu_lane i_alu_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .issue  (issue[i]),
            .op_a   (rd_data[2*i]),
            .op_b   (rd_data[2*i+1]),
            .retire (retire[i])
        );
    end

    // retire records double as write-back
    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wb      (retire)
    );

endmodule

`default_nettype wire

/* design/reg_file.sv */
// 32-entry register file with one rj and one rk read port per lane
// lane retire records write it and are forwarded to reads in the same cycle

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [issue_pkg::REG_ADDR_W-1:0]   rd_addr [issue_pkg::NUM_RD_PORTS],
    output logic [issue_pkg::XLEN-1:0]         rd_data [issue_pkg::NUM_RD_PORTS],
    input  issue_pkg::retire_t                 wb      [issue_pkg::NUM_LANES]
);
    import issue_pkg::*;

    logic [XLEN-1:0] regs  [NUM_REGS];
    logic            wr_en [NUM_LANES];

    // r0 is never written
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            wr_en[l] = wb[l].valid && wb[l].wen && (wb[l].rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // higher lane is younger, its write lands last
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wr_en[l]) begin
                    regs[wb[l].rd] <= wb[l].result;
                end
            end
        end
    end

    // bypass pending writes, younger lane checked last so it wins
    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rd_data[p] = regs[rd_addr[p]];
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wr_en[l] && (wb[l].rd == rd_addr[p])) begin
                    rd_data[p] = wb[l].result;
                end
            end
        end
    end

    for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_r0_chk
        a_r0_reads_zero: assert property (
            @(posedge clk) disable iff (!rst_n)
            (rd_addr[p] == '0) |-> (rd_data[p] == '0)
        );
    end

endmodule

`default_nettype wire

/* design/alu_lane.sv */
// one ALU execute lane
// computes the result of an issued op and registers its retire record

`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  logic                         clk,
    input  logic                         rst_n,
    input  issue_pkg::issue_t            issue,
    input  logic [issue_pkg::XLEN-1:0]   op_a,
    input  logic [issue_pkg::XLEN-1:0]   op_b,
    output issue_pkg::retire_t           retire
);
    import issue_pkg::*;

    logic [XLEN-1:0]         src_b;
    logic [$clog2(XLEN)-1:0] shamt;
    logic [XLEN-1:0]         result;
    retire_t                 nxt;

    // rk of zero selects the immediate form, shifts included
    assign src_b = (issue.uop.rk == '0) ? issue.uop.imm : op_b;
    assign shamt = src_b[$clog2(XLEN)-1:0];

    always_comb begin
        case (issue.uop.op)
            OP_ADD:  result = op_a + src_b;
            OP_SUB:  result = op_a - src_b;
            OP_AND:  result = op_a & src_b;
            OP_OR:   result = op_a | src_b;
            OP_XOR:  result = op_a ^ src_b;
            OP_SLL:  result = op_a << shamt;
            OP_SRL:  result = op_a >> shamt;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(src_b))};
            // upper immediate, low 12 bits cleared
            OP_LUI:  result = issue.uop.imm << 12;
            default: result = '0;
        endcase
    end

    always_comb begin
        nxt.valid  = issue.en;
        nxt.pc     = issue.uop.pc;
        nxt.rd     = issue.uop.rd;
        nxt.exc    = issue.uop.exc;
        nxt.wen    = issue.en
                   && (issue.uop.op != OP_NOP)
                   && (issue.uop.rd != '0)
                   && (issue.uop.exc == EXC_NONE);
        nxt.result = (issue.uop.exc == EXC_NONE) ? result : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire.valid <= 1'b0;
            retire.wen   <= 1'b0;
        end else begin
            retire <= nxt;
        end
    end

    a_retire_after_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire.valid |-> $past(issue.en)
    );

endmodule

`default_nettype wire

/* design/issue_buffer.sv */
// two-entry in-order issue buffer between the front end and the ALU lanes
// accepts up to two slots per cycle and issues the older entry to lane 0

`timescale 1ns/1ps
`default_nettype none

module issue_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              hold,
    input  logic              irq,
    input  issue_pkg::slot_t  fetch [issue_pkg::NUM_LANES],
    output logic [1:0]        take,
    output issue_pkg::issue_t issue [issue_pkg::NUM_LANES]
);
    import issue_pkg::*;

    uop_t       ent [NUM_LANES];
    logic [1:0] occ;

    logic       ne0;
    logic       ne1;
    uop_t       in_uop [NUM_LANES];
    logic [1:0] in_cnt;
    logic [1:0] acc_cnt;

    logic       head_nop;
    logic       pop0;
    logic       pair_ok;
    logic [1:0] out_cnt;
    logic [1:0] post_occ;

    // an excepting instruction must not execute
    function automatic uop_t force_nop(uop_t u);
        uop_t r;
        r = u;
        if (r.exc != EXC_NONE) begin
            r.op = OP_NOP;
        end
        return r;
    endfunction

    // a slot with neither valid nor an exception is empty
    assign ne0    = fetch[0].valid || (fetch[0].uop.exc != EXC_NONE);
    assign ne1    = fetch[1].valid || (fetch[1].uop.exc != EXC_NONE);
    assign in_cnt = {1'b0, ne0} + {1'b0, ne1};

    // slot 1 moves up when slot 0 is empty
    always_comb begin
        uop_t first;
        first = ne0 ? fetch[0].uop : fetch[1].uop;
        // pending interrupt lands on the oldest incoming instruction
        if (irq && (first.exc == EXC_NONE)) begin
            first.exc = EXC_INT;
        end
        in_uop[0] = force_nop(first);
        in_uop[1] = force_nop(fetch[1].uop);
    end

    // plain NOP drains without a strobe
    assign head_nop = (ent[0].op == OP_NOP) && (ent[0].exc == EXC_NONE);

    // nothing leaves during a flush, the whole buffer is dropped instead
    assign pop0 = (occ != 2'd0) && !hold && !flush;

    // lane 1 takes only an ALU op that does not read lane 0's result
    assign pair_ok = (occ == 2'd2)
                   && (ent[1].op != OP_NOP)
                   && (ent[1].exc == EXC_NONE)
                   && ((ent[0].rd == '0)
                       || ((ent[0].rd != ent[1].rj) && (ent[0].rd != ent[1].rk)));

    always_comb begin
        issue[0].en  = pop0 && !head_nop;
        issue[0].uop = ent[0];
        issue[1].en  = pop0 && !head_nop && pair_ok;
        issue[1].uop = ent[1];
    end

    assign out_cnt  = {1'b0, pop0} + {1'b0, issue[1].en};
    assign post_occ = occ - out_cnt;

    // free space after this cycle's issue
    assign take    = flush ? 2'd0 : (2'd2 - post_occ);
    assign acc_cnt = (in_cnt < take) ? in_cnt : take;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            occ <= 2'd0;
        end else begin
            occ <= post_occ + acc_cnt;
        end
    end

    // survivors shift to the head, new slots fill behind them
    always_ff @(posedge clk) begin
        case (post_occ)
            2'd0: begin
                ent[0] <= in_uop[0];
                ent[1] <= in_uop[1];
            end
            2'd1: begin
                ent[0] <= (out_cnt == 2'd0) ? ent[0] : ent[1];
                ent[1] <= in_uop[0];
            end
            default: begin
                ent[0] <= ent[0];
                ent[1] <= ent[1];
            end
        endcase
    end

    a_occ_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        occ != 2'd3
    );

    a_lane1_after_lane0: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue[1].en |-> issue[0].en
    );

    a_hold_no_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold |-> (!issue[0].en && !issue[1].en)
    );

endmodule

`default_nettype wire

/* design/issue_pkg.sv */
// shared types and constants of the dual-issue back end
// imported by the design modules and by the testbench

`default_nettype none

package issue_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int NUM_REGS     = 1 << REG_ADDR_W;
    localparam int NUM_LANES    = 2;
    // rj and rk for every lane
    localparam int NUM_RD_PORTS = 2 * NUM_LANES;

    // every op except NOP runs on either ALU lane
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLL = 4'd6,
        OP_SRL = 4'd7,
        OP_SLT = 4'd8,
        OP_LUI = 4'd9
    } opcode_e;

    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_INT     = 2'd1,
        EXC_ILLEGAL = 2'd2,
        EXC_FETCH   = 2'd3
    } exc_e;

    // one decoded instruction
    typedef struct packed {
        opcode_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        exc_e                  exc;
    } uop_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
    } slot_t;

    typedef struct packed {
        logic en;
        uop_t uop;
    } issue_t;

    // also used as the register file write port
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       result;
        exc_e                  exc;
    } retire_t;

endpackage

`default_nettype wire
